//--- flist.f
source/tcp_rx_msg_pkg.sv
source/resp_msg_if.sv
source/head_buf_table.sv
source/req_dispatch.sv
source/resp_lane.sv
source/noc_drain_arb.sv
source/tcp_rx_resp_tile.sv
sim/tb_clk_gen.sv
sim/tb_checker.sv
sim/tb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the TCP receive response tile testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_sim

verilator --binary --timing --top-module tb_top -f flist.f -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

//--- sim/tb_top.sv
`timescale 1ns/100ps
module tb_top import tcp_rx_msg_pkg::*; ();

    localparam int SRC_X = 2;
    localparam int SRC_Y = 5;
    localparam int NUM_LANES = 4;
    localparam int WAIT_LIMIT = 400;
    localparam int BURST_LEN = 12;

    logic                   clk;
    logic                   rst;
    logic                   req_val;
    logic [FLOWID_W-1:0]    req_flowid;
    logic [XY_W-1:0]        req_dst_x;
    logic [XY_W-1:0]        req_dst_y;
    logic [FBITS_W-1:0]     req_dst_fbits;
    logic                   buf_wr;
    logic [FLOWID_W-1:0]    buf_wr_flowid;
    tcp_buf_with_idx        buf_wr_data;
    logic [NOC_DATA_W-1:0]  noc_data;
    logic                   noc_val;
    logic                   noc_rdy;
    logic [DROP_CNT_W-1:0]  drop_cnt;

    int                     chk_errors;
    int                     msgs_rx;
    int                     msgs_open;
    int                     tb_errors;
    int                     reqs_sent;
    logic [31:0]            lcg_state;

    tb_clk_gen u_clk (
         .clk   (clk)
        ,.rst   (rst)
    );

    tcp_rx_resp_tile #(
         .SRC_X     (SRC_X)
        ,.SRC_Y     (SRC_Y)
        ,.NUM_LANES (NUM_LANES)
    ) uut (
         .clk           (clk)
        ,.rst           (rst)
        ,.req_val       (req_val)
        ,.req_flowid    (req_flowid)
        ,.req_dst_x     (req_dst_x)
        ,.req_dst_y     (req_dst_y)
        ,.req_dst_fbits (req_dst_fbits)
        ,.buf_wr        (buf_wr)
        ,.buf_wr_flowid (buf_wr_flowid)
        ,.buf_wr_data   (buf_wr_data)
        ,.noc_data      (noc_data)
        ,.noc_val       (noc_val)
        ,.noc_rdy       (noc_rdy)
        ,.drop_cnt      (drop_cnt)
    );

    tb_checker #(
         .SRC_X (SRC_X)
        ,.SRC_Y (SRC_Y)
    ) u_chk (
         .clk           (clk)
        ,.rst           (rst)
        ,.req_val       (req_val)
        ,.req_flowid    (req_flowid)
        ,.req_dst_x     (req_dst_x)
        ,.req_dst_y     (req_dst_y)
        ,.req_dst_fbits (req_dst_fbits)
        ,.buf_wr        (buf_wr)
        ,.buf_wr_flowid (buf_wr_flowid)
        ,.buf_wr_data   (buf_wr_data)
        ,.noc_data      (noc_data)
        ,.noc_val       (noc_val)
        ,.noc_rdy       (noc_rdy)
        ,.drop_cnt      (drop_cnt)
        ,.errors        (chk_errors)
        ,.msgs_rx       (msgs_rx)
        ,.msgs_open     (msgs_open)
    );

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic rand_word(output logic [31:0] value);
        lcg_state = lcg_next(lcg_state);
        value = lcg_state;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;                                 // Drive away from the edge.
    endtask

    task automatic clear_inputs();
        req_val = 1'b0;
        buf_wr = 1'b0;
    endtask

    task automatic put_request();
        logic [31:0] r;
        rand_word(r);
        req_val = 1'b1;
        req_flowid = r[19:16];
        req_dst_x = r[23:20];
        req_dst_y = r[27:24];
        req_dst_fbits = r[31:28];
        reqs_sent++;
    endtask

    task automatic put_write(input logic [FLOWID_W-1:0] flowid);
        logic [31:0] r0;
        logic [31:0] r1;
        rand_word(r0);
        rand_word(r1);
        buf_wr = 1'b1;
        buf_wr_flowid = flowid;
        buf_wr_data = {r0, r1[31:16], r1[15:8]};
    endtask

    task automatic wait_reset_done();
        int n;
        n = 0;
        @(posedge clk);                     // Reset is applied from time zero.
        while (rst !== 1'b0 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            tb_errors++;
            $display("Reset was never released");
        end
        #1;
    endtask

    task automatic wait_drained(input string what);
        int n;
        n = 0;
        next_cycle();                       // Let the last request reach the checker.
        while ((msgs_open != 0 || noc_val) && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (msgs_open != 0 || noc_val) begin
            tb_errors++;
            $display("Timeout draining after %s with %0d messages still expected",
                what, msgs_open);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0]            r;
        logic [DROP_CNT_W-1:0]  drops_before;
        lcg_state = 32'h29fc;
        tb_errors = 0;
        reqs_sent = 0;
        req_val = 1'b0;
        req_flowid = '0;
        req_dst_x = '0;
        req_dst_y = '0;
        req_dst_fbits = '0;
        buf_wr = 1'b0;
        buf_wr_flowid = '0;
        buf_wr_data = '0;
        noc_rdy = 1'b1;

        wait_reset_done();
        if (noc_val !== 1'b0) begin
            tb_errors++;
            $display("FAIL noc_val expected %h got %h", 1'b0, noc_val);
        end
        if (drop_cnt !== '0) begin
            tb_errors++;
            $display("FAIL drop_cnt expected %h got %h", 16'h0, drop_cnt);
        end

        // Fill the table, then single requests, some with a same-cycle write.
        for (int f = 0; f < 16; f++) begin
            put_write(4'(f));
            next_cycle();
        end
        clear_inputs();
        for (int i = 0; i < 16; i++) begin
            put_request();
            rand_word(r);
            if (r[30]) begin
                put_write(req_flowid);
            end
            next_cycle();
            clear_inputs();
            repeat (3) next_cycle();
        end
        wait_drained("single requests");
        if (drop_cnt !== '0) begin
            tb_errors++;
            $display("FAIL drop_cnt expected %h got %h", 16'h0, drop_cnt);
        end

        // Random back-pressure.
        for (int i = 0; i < 80; i++) begin
            rand_word(r);
            clear_inputs();
            noc_rdy = r[31];
            if (r[30] & r[29]) begin
                put_request();
            end
            if (r[28] & r[27]) begin
                put_write(r[23:20]);
            end
            next_cycle();
        end
        clear_inputs();
        noc_rdy = 1'b1;
        wait_drained("back-pressure");

        // Burst with the NoC stalled fills every lane.
        drops_before = drop_cnt;
        noc_rdy = 1'b0;
        for (int i = 0; i < BURST_LEN; i++) begin
            put_request();
            next_cycle();
        end
        clear_inputs();
        next_cycle();
        if (drop_cnt - drops_before !== DROP_CNT_W'(BURST_LEN - NUM_LANES)) begin
            tb_errors++;
            $display("FAIL drop_cnt expected %h got %h",
                drops_before + DROP_CNT_W'(BURST_LEN - NUM_LANES), drop_cnt);
        end
        noc_rdy = 1'b1;
        wait_drained("burst");

        if (msgs_open != 0) begin
            tb_errors++;
            $display("Expected list still holds %0d messages at the end", msgs_open);
        end
        if (msgs_rx + int'(drop_cnt) != reqs_sent) begin
            tb_errors++;
            $display("Received %0d plus dropped %0d does not match %0d requests sent",
                msgs_rx, drop_cnt, reqs_sent);
        end

        $display("Errors: checker %0d, sequence %0d, messages %0d, drops %0d",
            chk_errors, tb_errors, msgs_rx, drop_cnt);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("TESTBENCH PASSED");
        end
        else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #200000;
        $display("Simulation time limit reached before the sequence ended");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- sim/tb_checker.sv
`timescale 1ns/100ps
module tb_checker import tcp_rx_msg_pkg::*; #(
     parameter int SRC_X = 0
    ,parameter int SRC_Y = 0
)(
     input  logic                   clk
    ,input  logic                   rst
    ,input  logic                   req_val
    ,input  logic [FLOWID_W-1:0]    req_flowid
    ,input  logic [XY_W-1:0]        req_dst_x
    ,input  logic [XY_W-1:0]        req_dst_y
    ,input  logic [FBITS_W-1:0]     req_dst_fbits
    ,input  logic                   buf_wr
    ,input  logic [FLOWID_W-1:0]    buf_wr_flowid
    ,input  tcp_buf_with_idx        buf_wr_data
    ,input  logic [NOC_DATA_W-1:0]  noc_data
    ,input  logic                   noc_val
    ,input  logic                   noc_rdy
    ,input  logic [DROP_CNT_W-1:0]  drop_cnt
    ,output int                     errors
    ,output int                     msgs_rx
    ,output int                     msgs_open
);

    tcp_buf_with_idx        table_copy [16];
    logic [127:0]           exp_q [$];      // {header, body} per message.
    logic [127:0]           pend_msg;
    logic                   pend_val;
    logic [DROP_CNT_W-1:0]  pend_drops;
    logic                   in_body;
    logic [63:0]            hdr_seen;
    logic                   stalled;
    logic [63:0]            held_data;

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [127:0] expected_msg(
        input logic [3:0]       flowid,
        input logic [3:0]       dst_x,
        input logic [3:0]       dst_y,
        input logic [3:0]       dst_fbits,
        input tcp_buf_with_idx  head_buf
    );
        logic [63:0] hdr;
        logic [63:0] body;
        hdr = {dst_x, dst_y, dst_fbits, 8'h01, 8'h21, 4'(SRC_X), 4'(SRC_Y), 4'h3, 24'h0};
        body = {flowid, head_buf, 4'h0};
        return {hdr, body};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Compare
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        int             hit;
        logic [127:0]   got;
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                table_copy[i] = '0;
            end
            exp_q.delete();
            pend_val = 1'b0;
            in_body = 1'b0;
            stalled = 1'b0;
            errors = 0;
            msgs_rx = 0;
        end
        else begin
            // A request with no free lane shows up as a drop one edge later.
            if (pend_val && (drop_cnt != pend_drops + DROP_CNT_W'(1))) begin
                exp_q.push_back(pend_msg);
            end
            pend_val = 1'b0;

            if (stalled) begin
                if (!noc_val) begin
                    errors++;
                    $display("FAIL noc_val expected %h got %h", 1'b1, noc_val);
                end
                else if (noc_data != held_data) begin
                    errors++;
                    $display("FAIL noc_data expected %h got %h", held_data, noc_data);
                end
            end
            stalled = noc_val && !noc_rdy;
            held_data = noc_data;

            if (noc_val && noc_rdy) begin
                if (!in_body) begin
                    hdr_seen = noc_data;
                    in_body = 1'b1;
                end
                else begin
                    in_body = 1'b0;
                    got = {hdr_seen, noc_data};
                    hit = -1;
                    foreach (exp_q[i]) begin
                        if (hit < 0 && exp_q[i] == got) begin
                            hit = i;
                        end
                    end
                    msgs_rx++;
                    if (hit < 0) begin
                        errors++;
                        $display("FAIL noc_data header %h body %h matches no expected message",
                            hdr_seen, noc_data);
                    end
                    else begin
                        exp_q.delete(hit);
                    end
                end
            end

            // Lookup sees the entry from before this edge's write.
            if (req_val) begin
                pend_msg = expected_msg(req_flowid, req_dst_x, req_dst_y, req_dst_fbits,
                    table_copy[req_flowid]);
                pend_val = 1'b1;
                pend_drops = drop_cnt;
            end
            if (buf_wr) begin
                table_copy[buf_wr_flowid] = buf_wr_data;
            end
        end
        msgs_open = exp_q.size() + int'(pend_val);
    end

endmodule

//--- sim/tb_clk_gen.sv
`timescale 1ns/100ps
module tb_clk_gen #(
     parameter int PERIOD = 20
    ,parameter int RST_CYCLES = 2
)(
     output logic   clk
    ,output logic   rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;                      // Release just after the edge.
    end

endmodule

//--- source/tcp_rx_resp_tile.sv
`timescale 1ns/100ps
module tcp_rx_resp_tile import tcp_rx_msg_pkg::*; #(
     parameter int SRC_X = 0
    ,parameter int SRC_Y = 0
    ,parameter int NUM_LANES = 4
)(
     input  logic                   clk
    ,input  logic                   rst

    ,input  logic                   req_val
    ,input  logic [FLOWID_W-1:0]    req_flowid
    ,input  logic [XY_W-1:0]        req_dst_x
    ,input  logic [XY_W-1:0]        req_dst_y
    ,input  logic [FBITS_W-1:0]     req_dst_fbits

    ,input  logic                   buf_wr
    ,input  logic [FLOWID_W-1:0]    buf_wr_flowid
    ,input  tcp_buf_with_idx        buf_wr_data

    ,output logic [NOC_DATA_W-1:0]  noc_data
    ,output logic                   noc_val
    ,input  logic                   noc_rdy

    ,output logic [DROP_CNT_W-1:0]  drop_cnt
);

    logic [FLOWID_W-1:0]    rd_flowid;
    tcp_buf_with_idx        rd_buf;

    logic [NUM_LANES-1:0]   lane_msg_val;
    logic [NUM_LANES-1:0]   lane_done;
    noc_hdr_flit            lane_hdr [NUM_LANES];
    noc_body_flit           lane_body [NUM_LANES];

    resp_msg_if lane_if [NUM_LANES] ();

    //////////////////////////////////////////////////////////////////////
    // Lookup and dispatch
    //////////////////////////////////////////////////////////////////////

    head_buf_table u_table (
         .clk       (clk)
        ,.rst       (rst)
        ,.buf_wr    (buf_wr)
        ,.wr_flowid (buf_wr_flowid)
        ,.wr_buf    (buf_wr_data)
        ,.rd_flowid (rd_flowid)
        ,.rd_buf    (rd_buf)
    );

    req_dispatch #(
         .NUM_LANES (NUM_LANES)
    ) u_dispatch (
         .clk           (clk)
        ,.rst           (rst)
        ,.req_val       (req_val)
        ,.req_flowid    (req_flowid)
        ,.req_dst_x     (req_dst_x)
        ,.req_dst_y     (req_dst_y)
        ,.req_dst_fbits (req_dst_fbits)
        ,.rd_flowid     (rd_flowid)
        ,.rd_buf        (rd_buf)
        ,.lanes         (lane_if)
        ,.drop_cnt      (drop_cnt)
    );

    //////////////////////////////////////////////////////////////////////
    // Lanes and drain
    //////////////////////////////////////////////////////////////////////

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        resp_lane #(
             .SRC_X (SRC_X)
            ,.SRC_Y (SRC_Y)
        ) u_lane (
             .clk       (clk)
            ,.rst       (rst)
            ,.msg_if    (lane_if[g])
            ,.done      (lane_done[g])
            ,.msg_val   (lane_msg_val[g])
            ,.hdr_flit  (lane_hdr[g])
            ,.body_flit (lane_body[g])
        );
    end

    noc_drain_arb #(
         .NUM_LANES (NUM_LANES)
    ) u_arb (
         .clk       (clk)
        ,.rst       (rst)
        ,.msg_val   (lane_msg_val)
        ,.hdr_flit  (lane_hdr)
        ,.body_flit (lane_body)
        ,.done      (lane_done)
        ,.noc_data  (noc_data)
        ,.noc_val   (noc_val)
        ,.noc_rdy   (noc_rdy)
    );

endmodule

//--- source/noc_drain_arb.sv
`timescale 1ns/100ps
module noc_drain_arb import tcp_rx_msg_pkg::*; #(
     parameter int NUM_LANES = 4
)(
     input  logic                   clk
    ,input  logic                   rst

    ,input  logic [NUM_LANES-1:0]   msg_val
    ,input  noc_hdr_flit            hdr_flit [NUM_LANES]
    ,input  noc_body_flit           body_flit [NUM_LANES]
    ,output logic [NUM_LANES-1:0]   done

    ,output logic [NOC_DATA_W-1:0]  noc_data
    ,output logic                   noc_val
    ,input  logic                   noc_rdy
);

    localparam int IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic               locked;     // Grant held for a message in flight.
    logic               phase_reg;  // Set once the header is accepted.
    logic [IDX_W-1:0]   grant_reg;
    logic [IDX_W-1:0]   last_grant;

    logic [IDX_W-1:0]   rr_idx;
    logic [IDX_W-1:0]   pick;
    logic [IDX_W-1:0]   cur_grant;
    logic               body_sel;
    logic               any_val;

    //////////////////////////////////////////////////////////////////////
    // Round-robin pick
    //////////////////////////////////////////////////////////////////////

    assign any_val = |msg_val;

    always_comb begin
        pick = last_grant;
        rr_idx = last_grant;
        // Walk back toward last_grant so the nearest lane after it wins.
        for (int k = NUM_LANES; k >= 1; k--) begin
            rr_idx = IDX_W'((int'(last_grant) + k) % NUM_LANES);
            if (msg_val[rr_idx]) begin
                pick = rr_idx;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output mux
    //////////////////////////////////////////////////////////////////////

    assign cur_grant = locked ? grant_reg : pick;
    assign body_sel = locked & phase_reg;

    assign noc_val = msg_val[cur_grant];
    assign noc_data = body_sel ? body_flit[cur_grant] : hdr_flit[cur_grant];

    always_comb begin
        done = '0;
        if (body_sel && noc_rdy) begin
            done[grant_reg] = 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Grant state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            locked <= 1'b0;
            phase_reg <= 1'b0;
            grant_reg <= '0;
            last_grant <= IDX_W'(NUM_LANES - 1);   // Lane 0 served first.
        end
        else if (!locked) begin
            if (any_val) begin
                // Lock on first presentation so a stalled header stays put.
                locked <= 1'b1;
                grant_reg <= pick;
                phase_reg <= noc_rdy;
            end
        end
        else if (noc_rdy) begin
            if (!phase_reg) begin
                phase_reg <= 1'b1;
            end
            else begin
                locked <= 1'b0;
                phase_reg <= 1'b0;
                last_grant <= grant_reg;
            end
        end
    end

endmodule

//--- source/resp_lane.sv
`timescale 1ns/100ps
module resp_lane import tcp_rx_msg_pkg::*; #(
     parameter int SRC_X = 0
    ,parameter int SRC_Y = 0
)(
     input  logic           clk
    ,input  logic           rst

    ,resp_msg_if.lane       msg_if

    ,input  logic           done
    ,output logic           msg_val
    ,output noc_hdr_flit    hdr_flit
    ,output noc_body_flit   body_flit
);

    logic [FLOWID_W-1:0]    flowid_reg;
    tcp_buf_with_idx        head_buf_reg;
    logic [XY_W-1:0]        dst_x_reg;
    logic [XY_W-1:0]        dst_y_reg;
    logic [FBITS_W-1:0]     dst_fbits_reg;

    logic [FLOWID_W-1:0]    flowid_next;
    tcp_buf_with_idx        head_buf_next;
    logic [XY_W-1:0]        dst_x_next;
    logic [XY_W-1:0]        dst_y_next;
    logic [FBITS_W-1:0]     dst_fbits_next;

    logic                   busy_reg;

    //////////////////////////////////////////////////////////////////////
    // Request storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        flowid_reg <= flowid_next;
        head_buf_reg <= head_buf_next;
        dst_x_reg <= dst_x_next;
        dst_y_reg <= dst_y_next;
        dst_fbits_reg <= dst_fbits_next;
    end

    always_comb begin
        if (msg_if.store) begin
            flowid_next = msg_if.flowid;
            head_buf_next = msg_if.head_buf;
            dst_x_next = msg_if.dst_x;
            dst_y_next = msg_if.dst_y;
            dst_fbits_next = msg_if.dst_fbits;
        end
        else begin
            flowid_next = flowid_reg;
            head_buf_next = head_buf_reg;
            dst_x_next = dst_x_reg;
            dst_y_next = dst_y_reg;
            dst_fbits_next = dst_fbits_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_reg <= 1'b0;
        end
        else if (msg_if.store) begin
            busy_reg <= 1'b1;
        end
        else if (done) begin
            busy_reg <= 1'b0;       // Body flit taken by the NoC.
        end
    end

    assign msg_if.busy = busy_reg;
    assign msg_val = busy_reg;

    //////////////////////////////////////////////////////////////////////
    // Flit build
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        hdr_flit = '0;
        hdr_flit.dst_x = dst_x_reg;
        hdr_flit.dst_y = dst_y_reg;
        hdr_flit.dst_fbits = dst_fbits_reg;
        hdr_flit.msg_len = MSG_LEN_W'(1);
        hdr_flit.msg_type = TCP_RX_MSG_RESP;
        hdr_flit.src_x = SRC_X[XY_W-1:0];
        hdr_flit.src_y = SRC_Y[XY_W-1:0];
        hdr_flit.src_fbits = TCP_RX_APP_PTR_IF_FBITS;

        body_flit = '0;
        body_flit.flowid = flowid_reg;
        body_flit.resp_buf = head_buf_reg;
    end

endmodule

//--- source/req_dispatch.sv
`timescale 1ns/100ps
module req_dispatch import tcp_rx_msg_pkg::*; #(
     parameter int NUM_LANES = 4
)(
     input  logic                       clk
    ,input  logic                       rst

    ,input  logic                       req_val
    ,input  logic [FLOWID_W-1:0]        req_flowid
    ,input  logic [XY_W-1:0]            req_dst_x
    ,input  logic [XY_W-1:0]            req_dst_y
    ,input  logic [FBITS_W-1:0]         req_dst_fbits

    ,output logic [FLOWID_W-1:0]        rd_flowid
    ,input  tcp_buf_with_idx            rd_buf

    ,resp_msg_if.dispatcher             lanes [NUM_LANES]

    ,output logic [DROP_CNT_W-1:0]      drop_cnt
);

    logic [NUM_LANES-1:0]   busy_vec;
    logic [NUM_LANES-1:0]   idle_vec;
    logic [NUM_LANES-1:0]   store_vec;
    logic                   all_busy;

    assign rd_flowid = req_flowid;

    //////////////////////////////////////////////////////////////////////
    // Lane select
    //////////////////////////////////////////////////////////////////////

    assign idle_vec = ~busy_vec;
    assign all_busy = &busy_vec;

    // Lowest set bit of the idle vector.
    assign store_vec = req_val ? (idle_vec & (-idle_vec)) : '0;

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        assign busy_vec[g] = lanes[g].busy;

        assign lanes[g].store = store_vec[g];
        assign lanes[g].flowid = req_flowid;
        assign lanes[g].head_buf = rd_buf;
        assign lanes[g].dst_x = req_dst_x;
        assign lanes[g].dst_y = req_dst_y;
        assign lanes[g].dst_fbits = req_dst_fbits;
    end

    //////////////////////////////////////////////////////////////////////
    // Drop counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            drop_cnt <= '0;
        end
        else if (req_val && all_busy && (drop_cnt != '1)) begin
            drop_cnt <= drop_cnt + DROP_CNT_W'(1);   // Saturates at all ones.
        end
    end

endmodule

//--- source/head_buf_table.sv
`timescale 1ns/100ps
module head_buf_table import tcp_rx_msg_pkg::*; (
     input  logic                   clk
    ,input  logic                   rst

    ,input  logic                   buf_wr
    ,input  logic [FLOWID_W-1:0]    wr_flowid
    ,input  tcp_buf_with_idx        wr_buf

    ,input  logic [FLOWID_W-1:0]    rd_flowid
    ,output tcp_buf_with_idx        rd_buf
);

    tcp_buf_with_idx    entries [NUM_FLOWS];

    //////////////////////////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_FLOWS; i++) begin
                entries[i] <= '0;
            end
        end
        else if (buf_wr) begin
            entries[wr_flowid] <= wr_buf;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////////////////////////

    // A read in the write cycle still sees the old entry.
    assign rd_buf = entries[rd_flowid];

endmodule

//--- source/resp_msg_if.sv
`timescale 1ns/100ps
interface resp_msg_if import tcp_rx_msg_pkg::*; ();

    logic                   store;      // One cycle, request goes to this lane.
    logic [FLOWID_W-1:0]    flowid;
    tcp_buf_with_idx        head_buf;
    logic [XY_W-1:0]        dst_x;
    logic [XY_W-1:0]        dst_y;
    logic [FBITS_W-1:0]     dst_fbits;
    logic                   busy;       // Lane holds a message not yet sent.

    modport dispatcher (
         output store
        ,output flowid
        ,output head_buf
        ,output dst_x
        ,output dst_y
        ,output dst_fbits
        ,input  busy
    );

    modport lane (
         input  store
        ,input  flowid
        ,input  head_buf
        ,input  dst_x
        ,input  dst_y
        ,input  dst_fbits
        ,output busy
    );

endinterface

//--- source/tcp_rx_msg_pkg.sv
package tcp_rx_msg_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    localparam int NOC_DATA_W = 64;
    localparam int XY_W = 4;
    localparam int FBITS_W = 4;
    localparam int FLOWID_W = 4;
    localparam int NUM_FLOWS = 1 << FLOWID_W;
    localparam int DROP_CNT_W = 16;

    localparam int BUF_ADDR_W = 32;
    localparam int BUF_SIZE_W = 16;
    localparam int BUF_IDX_W = 8;
    localparam int MSG_LEN_W = 8;
    localparam int MSG_TYPE_W = 8;

    //////////////////////////////////////////////////////////////////////
    // Message constants
    //////////////////////////////////////////////////////////////////////

    localparam logic [MSG_TYPE_W-1:0] TCP_RX_MSG_RESP = 8'h21;
    localparam logic [FBITS_W-1:0] TCP_RX_APP_PTR_IF_FBITS = 4'h3;

    //////////////////////////////////////////////////////////////////////
    // Buffer and flit layouts
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [BUF_ADDR_W-1:0]  buf_addr;
        logic [BUF_SIZE_W-1:0]  buf_size;
        logic [BUF_IDX_W-1:0]   buf_idx;
    } tcp_buf_with_idx;

    typedef struct packed {
        logic [XY_W-1:0]        dst_x;
        logic [XY_W-1:0]        dst_y;
        logic [FBITS_W-1:0]     dst_fbits;
        logic [MSG_LEN_W-1:0]   msg_len;    // Body flits that follow.
        logic [MSG_TYPE_W-1:0]  msg_type;
        logic [XY_W-1:0]        src_x;
        logic [XY_W-1:0]        src_y;
        logic [FBITS_W-1:0]     src_fbits;
        logic [NOC_DATA_W-4*XY_W-2*FBITS_W-MSG_LEN_W-MSG_TYPE_W-1:0] pad;
    } noc_hdr_flit;

    typedef struct packed {
        logic [FLOWID_W-1:0]    flowid;
        tcp_buf_with_idx        resp_buf;
        logic [NOC_DATA_W-FLOWID_W-$bits(tcp_buf_with_idx)-1:0] pad;
    } noc_body_flit;

endpackage
